/* bank_issue.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_bank_consts.svh"

module bank_issue (
   input  wire                                       clk,
   input  wire                                       reset,
   input  wire                                       pipe_en,
   input  wire                                       valid_b,
   input  wire cache_bank_pkg::ref_idx_t             ref_idx_b,
   input  wire cache_bank_pkg::line_x_t              line_x_b,
   input  wire cache_bank_pkg::line_y_t              line_y_b,
   input  wire                                       hit,
   input  wire cache_bank_pkg::way_t                 hit_way,
   input  wire cache_bank_pkg::way_t                 victim_way,
   input  wire cache_bank_pkg::set_addr_t            set_b,
   input  wire cache_bank_pkg::tag_t                 tag_b,
   input  wire cache_bank_pkg::age_t [`CB_WAYS-1:0]  ages_b,
   input  wire                                       dest_en,
   input  wire cache_bank_pkg::col_t                 col_first,
   input  wire cache_bank_pkg::col_t                 col_last,
   input  wire cache_bank_pkg::row_t                 row_first,
   input  wire cache_bank_pkg::row_t                 row_last,
   output logic                                      wr_en,
   output cache_bank_pkg::set_addr_t                 wr_set,
   output cache_bank_pkg::way_t                      wr_way,
   output cache_bank_pkg::tag_t                      wr_tag,
   output cache_bank_pkg::age_t [`CB_WAYS-1:0]       wr_ages,
   output logic                                      res_valid,
   output logic                                      res_dest_en,
   output logic                                      res_hit,
   output cache_bank_pkg::way_t                      res_way,
   output cache_bank_pkg::set_addr_t                 res_set,
   output cache_bank_pkg::mem_addr_t                 res_miss_addr,
   output cache_bank_pkg::col_t                      res_col_first,
   output cache_bank_pkg::col_t                      res_col_last,
   output cache_bank_pkg::row_t                      res_row_first,
   output cache_bank_pkg::row_t                      res_row_last
);
   import cache_bank_pkg::*;

   logic                  use_en;
   way_t                  use_way;
   age_t                  use_age;
   age_t [`CB_WAYS-1:0]   new_ages;
   mem_addr_t             miss_addr;

   assign use_en  = valid_b && dest_en;
   assign use_way = hit ? hit_way : victim_way;   // victim on a miss
   assign use_age = ages_b[use_way];

   // ------------------------------------------------
   // age update
   // ------------------------------------------------
   always_comb begin
      for (int w = 0; w < `CB_WAYS; w++) begin
         if (way_t'(w) == use_way)
            new_ages[w] = '0;
         else if (ages_b[w] < use_age)
            new_ages[w] = ages_b[w] + 1'b1;
         else
            new_ages[w] = ages_b[w];
      end
   end

   assign miss_addr = mem_addr_t'({ref_idx_b, line_y_b, line_x_b}) << `CB_LINE_BYTES_LOG;

   // store write on the B to C edge
   assign wr_en   = pipe_en && use_en;
   assign wr_set  = set_b;
   assign wr_way  = use_way;
   assign wr_tag  = tag_b;   // rewrites the same tag on a hit
   assign wr_ages = new_ages;

   // ------------------------------------------------
   // stage C result register
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         res_valid <= 1'b0;
      end else if (pipe_en) begin
         res_valid <= valid_b;
      end
   end

   always_ff @(posedge clk) begin
      if (pipe_en) begin
         res_dest_en   <= dest_en;
         res_hit       <= use_en && hit;
         res_way       <= use_en ? use_way : '0;
         res_set       <= set_b;
         res_miss_addr <= (use_en && !hit) ? miss_addr : '0;
         res_col_first <= col_first;   // already zero when disabled
         res_col_last  <= col_last;
         res_row_first <= row_first;
         res_row_last  <= row_last;
      end
   end

endmodule

`default_nettype wire

/* cache_bank.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_bank_consts.svh"

module cache_bank (
   input  wire                              clk,
   input  wire                              reset,
   input  wire                              req_valid,
   output logic                             req_ready,
   input  wire cache_bank_pkg::line_x_t     line_x,
   input  wire cache_bank_pkg::line_y_t     line_y,
   input  wire cache_bank_pkg::ref_idx_t    ref_idx,
   input  wire cache_bank_pkg::pix_x_t      blk_x,
   input  wire cache_bank_pkg::pix_y_t      blk_y,
   input  wire cache_bank_pkg::dim_t        blk_w,
   input  wire cache_bank_pkg::dim_t        blk_h,
   input  wire                              res_ready,
   output logic                             res_valid,
   output logic                             res_dest_en,
   output logic                             res_hit,
   output cache_bank_pkg::way_t             res_way,
   output cache_bank_pkg::set_addr_t        res_set,
   output cache_bank_pkg::mem_addr_t        res_miss_addr,
   output cache_bank_pkg::col_t             res_col_first,
   output cache_bank_pkg::col_t             res_col_last,
   output cache_bank_pkg::row_t             res_row_first,
   output cache_bank_pkg::row_t             res_row_last
);
   import cache_bank_pkg::*;

   logic                  pipe_en;
   // stage A request
   logic                  valid_a;
   line_x_t               line_x_a;
   line_y_t               line_y_a;
   ref_idx_t              ref_idx_a;
   pix_x_t                blk_x_a;
   pix_y_t                blk_y_a;
   dim_t                  blk_w_a;
   dim_t                  blk_h_a;
   set_addr_t             rd_set;
   tag_t                  rd_tag;
   // stage B request
   logic                  valid_b;
   line_x_t               line_x_b;
   line_y_t               line_y_b;
   ref_idx_t              ref_idx_b;
   // lookup and window results
   logic                  hit;
   way_t                  hit_way;
   way_t                  victim_way;
   set_addr_t             set_b;
   tag_t                  tag_b;
   age_t [`CB_WAYS-1:0]   ages_b;
   logic                  dest_en;
   col_t                  col_first;
   col_t                  col_last;
   row_t                  row_first;
   row_t                  row_last;
   // store write
   logic                  wr_en;
   set_addr_t             wr_set;
   way_t                  wr_way;
   tag_t                  wr_tag;
   age_t [`CB_WAYS-1:0]   wr_ages;

   // one enable moves every stage
   assign pipe_en   = !res_valid || res_ready;
   assign req_ready = pipe_en;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_a <= 1'b0;
         valid_b <= 1'b0;
      end else if (pipe_en) begin
         valid_a <= req_valid;
         valid_b <= valid_a;
      end
   end

   always_ff @(posedge clk) begin
      if (pipe_en) begin
         line_x_a  <= line_x;
         line_y_a  <= line_y;
         ref_idx_a <= ref_idx;
         blk_x_a   <= blk_x;
         blk_y_a   <= blk_y;
         blk_w_a   <= blk_w;
         blk_h_a   <= blk_h;
         line_x_b  <= line_x_a;
         line_y_b  <= line_y_a;
         ref_idx_b <= ref_idx_a;
      end
   end

   // low row bits above low column bits
   assign rd_set = {line_y_a[`CB_SET_Y-1:0], line_x_a[`CB_SET_X-1:0]};
   assign rd_tag = {ref_idx_a, line_y_a[`CB_LINE_Y_BITS-1:`CB_SET_Y],
                    line_x_a[`CB_LINE_X_BITS-1:`CB_SET_X]};

   // ------------------------------------------------
   // lookup, window, issue
   // ------------------------------------------------
   tag_lookup u_tag_lookup (
      .clk        (clk),
      .reset      (reset),
      .pipe_en    (pipe_en),
      .rd_set     (rd_set),
      .rd_tag     (rd_tag),
      .wr_en      (wr_en),
      .wr_set     (wr_set),
      .wr_way     (wr_way),
      .wr_tag     (wr_tag),
      .wr_ages    (wr_ages),
      .hit        (hit),
      .hit_way    (hit_way),
      .victim_way (victim_way),
      .set_b      (set_b),
      .tag_b      (tag_b),
      .ages_b     (ages_b)
   );

   dest_window u_dest_window (
      .clk       (clk),
      .reset     (reset),
      .pipe_en   (pipe_en),
      .line_x    (line_x_a),
      .line_y    (line_y_a),
      .blk_x     (blk_x_a),
      .blk_y     (blk_y_a),
      .blk_w     (blk_w_a),
      .blk_h     (blk_h_a),
      .dest_en   (dest_en),
      .col_first (col_first),
      .col_last  (col_last),
      .row_first (row_first),
      .row_last  (row_last)
   );

   bank_issue u_bank_issue (
      .clk           (clk),
      .reset         (reset),
      .pipe_en       (pipe_en),
      .valid_b       (valid_b),
      .ref_idx_b     (ref_idx_b),
      .line_x_b      (line_x_b),
      .line_y_b      (line_y_b),
      .hit           (hit),
      .hit_way       (hit_way),
      .victim_way    (victim_way),
      .set_b         (set_b),
      .tag_b         (tag_b),
      .ages_b        (ages_b),
      .dest_en       (dest_en),
      .col_first     (col_first),
      .col_last      (col_last),
      .row_first     (row_first),
      .row_last      (row_last),
      .wr_en         (wr_en),
      .wr_set        (wr_set),
      .wr_way        (wr_way),
      .wr_tag        (wr_tag),
      .wr_ages       (wr_ages),
      .res_valid     (res_valid),
      .res_dest_en   (res_dest_en),
      .res_hit       (res_hit),
      .res_way       (res_way),
      .res_set       (res_set),
      .res_miss_addr (res_miss_addr),
      .res_col_first (res_col_first),
      .res_col_last  (res_col_last),
      .res_row_first (res_row_first),
      .res_row_last  (res_row_last)
   );

endmodule

`default_nettype wire

/* cache_bank_consts.svh */
`ifndef CACHE_BANK_CONSTS_SVH
`define CACHE_BANK_CONSTS_SVH

// ------------------------------------------------
// picture and line geometry
// ------------------------------------------------
`define CB_X_BITS          11    // luma pixel x
`define CB_Y_BITS          11    // luma pixel y
`define CB_LINE_H          3     // 8 pixels per line
`define CB_LINE_V          2     // 4 rows per line
`define CB_LINE_X_BITS     (`CB_X_BITS - `CB_LINE_H)
`define CB_LINE_Y_BITS     (`CB_Y_BITS - `CB_LINE_V)
`define CB_DIM_BITS        7
`define CB_REF_BITS        4

// ------------------------------------------------
// set and way geometry
// ------------------------------------------------
`define CB_SET_X           3     // set bits from line x
`define CB_SET_Y           2     // set bits from line y
`define CB_SET_BITS        (`CB_SET_X + `CB_SET_Y)
`define CB_SETS            (1 << `CB_SET_BITS)
`define CB_WAY_BITS        2
`define CB_WAYS            (1 << `CB_WAY_BITS)
`define CB_TAG_BITS        (`CB_REF_BITS + `CB_LINE_Y_BITS - `CB_SET_Y + `CB_LINE_X_BITS - `CB_SET_X)

// external memory
`define CB_MEM_ADDR_BITS   32
`define CB_LINE_BYTES_LOG  5     // 32 bytes per line

`endif

/* cache_bank_pkg.sv */
`default_nettype none
`include "cache_bank_consts.svh"

package cache_bank_pkg;

   // pixel and line coordinates
   typedef logic [`CB_X_BITS-1:0]         pix_x_t;
   typedef logic [`CB_Y_BITS-1:0]         pix_y_t;
   typedef logic [`CB_LINE_X_BITS-1:0]    line_x_t;
   typedef logic [`CB_LINE_Y_BITS-1:0]    line_y_t;
   typedef logic [`CB_REF_BITS-1:0]       ref_idx_t;
   typedef logic [`CB_DIM_BITS-1:0]       dim_t;     // block width or height

   // ------------------------------------------------
   // tag store
   // ------------------------------------------------
   typedef logic [`CB_SET_BITS-1:0]       set_addr_t;
   typedef logic [`CB_TAG_BITS-1:0]       tag_t;     // ref, upper row, upper col
   typedef logic [`CB_WAY_BITS-1:0]       way_t;
   typedef logic [`CB_WAY_BITS-1:0]       age_t;     // 0 is most recent
   typedef logic [`CB_WAYS-1:0]           way_vec_t;

   // position inside a line
   typedef logic [`CB_LINE_H-1:0]         col_t;
   typedef logic [`CB_LINE_V-1:0]         row_t;

   typedef logic [`CB_MEM_ADDR_BITS-1:0]  mem_addr_t;

endpackage

`default_nettype wire

/* dest_window.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_bank_consts.svh"

module dest_window (
   input  wire                              clk,
   input  wire                              reset,
   input  wire                              pipe_en,
   input  wire cache_bank_pkg::line_x_t     line_x,
   input  wire cache_bank_pkg::line_y_t     line_y,
   input  wire cache_bank_pkg::pix_x_t      blk_x,
   input  wire cache_bank_pkg::pix_y_t      blk_y,
   input  wire cache_bank_pkg::dim_t        blk_w,
   input  wire cache_bank_pkg::dim_t        blk_h,
   output logic                             dest_en,
   output cache_bank_pkg::col_t             col_first,
   output cache_bank_pkg::col_t             col_last,
   output cache_bank_pkg::row_t             row_first,
   output cache_bank_pkg::row_t             row_last
);
   import cache_bank_pkg::*;

   // one extra bit so exclusive right and bottom edges fit
   logic [`CB_X_BITS:0]  x_l;
   logic [`CB_X_BITS:0]  x_r;
   logic [`CB_X_BITS:0]  bx_r;
   logic [`CB_X_BITS:0]  x_lo;
   logic [`CB_X_BITS:0]  x_hi;
   logic [`CB_Y_BITS:0]  y_t;
   logic [`CB_Y_BITS:0]  y_b;
   logic [`CB_Y_BITS:0]  by_b;
   logic [`CB_Y_BITS:0]  y_lo;
   logic [`CB_Y_BITS:0]  y_hi;
   logic                 overlap;

   always_comb begin
      x_l  = {1'b0, line_x, {`CB_LINE_H{1'b0}}};
      x_r  = x_l + (`CB_X_BITS+1)'(1 << `CB_LINE_H);
      bx_r = {1'b0, blk_x} + (`CB_X_BITS+1)'(blk_w);
      x_lo = (x_l > {1'b0, blk_x}) ? x_l : {1'b0, blk_x};
      x_hi = (x_r < bx_r) ? x_r : bx_r;

      y_t  = {1'b0, line_y, {`CB_LINE_V{1'b0}}};
      y_b  = y_t + (`CB_Y_BITS+1)'(1 << `CB_LINE_V);
      by_b = {1'b0, blk_y} + (`CB_Y_BITS+1)'(blk_h);
      y_lo = (y_t > {1'b0, blk_y}) ? y_t : {1'b0, blk_y};
      y_hi = (y_b < by_b) ? y_b : by_b;

      overlap = (x_lo < x_hi) && (y_lo < y_hi);   // empty block never overlaps
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         dest_en <= 1'b0;
      end else if (pipe_en) begin
         dest_en <= overlap;
      end
   end

   // range relative to the line's top left corner
   always_ff @(posedge clk) begin
      if (pipe_en) begin
         col_first <= overlap ? col_t'(x_lo - x_l) : '0;
         col_last  <= overlap ? col_t'(x_hi - x_l - 1'b1) : '0;
         row_first <= overlap ? row_t'(y_lo - y_t) : '0;
         row_last  <= overlap ? row_t'(y_hi - y_t - 1'b1) : '0;
      end
   end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
cache_bank_pkg.sv
tag_lookup.sv
dest_window.sv
bank_issue.sv
cache_bank.sv
tb_cache_bank.sv

/* run.sh */
#!/bin/sh
# build and run the cache bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_cache_bank -f list.f -o sim_cache_bank
./obj_dir/sim_cache_bank > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
   exit 1
fi

/* tag_lookup.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_bank_consts.svh"

module tag_lookup (
   input  wire                                       clk,
   input  wire                                       reset,
   input  wire                                       pipe_en,
   input  wire cache_bank_pkg::set_addr_t            rd_set,
   input  wire cache_bank_pkg::tag_t                 rd_tag,
   input  wire                                       wr_en,
   input  wire cache_bank_pkg::set_addr_t            wr_set,
   input  wire cache_bank_pkg::way_t                 wr_way,
   input  wire cache_bank_pkg::tag_t                 wr_tag,
   input  wire cache_bank_pkg::age_t [`CB_WAYS-1:0]  wr_ages,
   output logic                                      hit,
   output cache_bank_pkg::way_t                      hit_way,
   output cache_bank_pkg::way_t                      victim_way,
   output cache_bank_pkg::set_addr_t                 set_b,
   output cache_bank_pkg::tag_t                      tag_b,
   output cache_bank_pkg::age_t [`CB_WAYS-1:0]       ages_b
);
   import cache_bank_pkg::*;

   tag_t                  tag_mem [`CB_SETS][`CB_WAYS];
   way_vec_t              valid_mem [`CB_SETS];
   age_t [`CB_WAYS-1:0]   age_mem [`CB_SETS];

   tag_t                  tags_q [`CB_WAYS];   // stage B copy of the set
   way_vec_t              vld_q;
   way_vec_t              hit_vec;
   logic                  fwd;

   // write from the item leaving B lands on the set entering B
   assign fwd = wr_en && (wr_set == rd_set);

   // ------------------------------------------------
   // storage
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         tag_mem[wr_set][wr_way] <= wr_tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < `CB_SETS; s++) begin
            valid_mem[s] <= '0;
            for (int w = 0; w < `CB_WAYS; w++) begin
               age_mem[s][w] <= age_t'(w);   // ways start at ages 0..3
            end
         end
      end else if (wr_en) begin
         valid_mem[wr_set][wr_way] <= 1'b1;
         age_mem[wr_set] <= wr_ages;
      end
   end

   // ------------------------------------------------
   // stage B read register with forwarding
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (pipe_en) begin
         set_b  <= rd_set;
         tag_b  <= rd_tag;
         ages_b <= fwd ? wr_ages : age_mem[rd_set];
         for (int w = 0; w < `CB_WAYS; w++) begin
            if (fwd && (wr_way == way_t'(w))) begin
               tags_q[w] <= wr_tag;
               vld_q[w]  <= 1'b1;
            end else begin
               tags_q[w] <= tag_mem[rd_set][w];
               vld_q[w]  <= valid_mem[rd_set][w];
            end
         end
      end
   end

   // tag compare
   always_comb begin
      hit_vec = '0;
      hit_way = '0;
      for (int w = 0; w < `CB_WAYS; w++) begin
         hit_vec[w] = vld_q[w] && (tags_q[w] == tag_b);
         if (hit_vec[w])
            hit_way = way_t'(w);
      end
   end

   assign hit = |hit_vec;

   // lowest invalid way wins, otherwise the oldest one
   always_comb begin
      victim_way = '0;
      for (int w = 0; w < `CB_WAYS; w++) begin
         if (ages_b[w] == '1)
            victim_way = way_t'(w);
      end
      for (int w = `CB_WAYS - 1; w >= 0; w--) begin
         if (!vld_q[w])
            victim_way = way_t'(w);
      end
   end

endmodule

`default_nettype wire

/* tb_cache_bank.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cache_bank_consts.svh"

module tb_cache_bank;
   import cache_bank_pkg::*;

   localparam int n_req = 2400;   // upper bound on requests sent

   typedef logic [$bits(ref_idx_t)+$bits(line_y_t)+$bits(line_x_t)-1:0] line_id_t;

   typedef struct packed {
      logic          dest_en;
      logic          hit;
      way_t          way;
      set_addr_t     set;
      mem_addr_t     addr;
      col_t          col_first;
      col_t          col_last;
      row_t          row_first;
      row_t          row_last;
      logic          timed;       // accepted while res_ready held high
      logic [31:0]   acc_cycle;
   } exp_t;

   logic          clk;
   logic          reset;
   logic          req_valid;
   logic          req_ready;
   line_x_t       line_x;
   line_y_t       line_y;
   ref_idx_t      ref_idx;
   pix_x_t        blk_x;
   pix_y_t        blk_y;
   dim_t          blk_w;
   dim_t          blk_h;
   logic          res_ready;
   logic          res_valid;
   logic          res_dest_en;
   logic          res_hit;
   way_t          res_way;
   set_addr_t     res_set;
   mem_addr_t     res_miss_addr;
   col_t          res_col_first;
   col_t          res_col_last;
   row_t          res_row_first;
   row_t          res_row_last;
   logic [50:0]   res_bits;
   logic [50:0]   held_bits;

   // reference cache state
   exp_t          exp_q[$];
   line_id_t      m_line [`CB_SETS][`CB_WAYS];
   logic          m_valid [`CB_SETS][`CB_WAYS];
   int            m_age [`CB_SETS][`CB_WAYS];

   int            ready_mode = 0;   // 0 held high, 1 half, 2 mostly high
   int            cycle = 0;
   int            val_errs = 0;
   int            other_errs = 0;
   int            n_checked = 0;
   logic          stalled = 1'b0;

   assign res_bits = {res_dest_en, res_hit, res_way, res_set, res_miss_addr,
                      res_col_first, res_col_last, res_row_first, res_row_last};

   cache_bank u_cache_bank (
      .clk           (clk),
      .reset         (reset),
      .req_valid     (req_valid),
      .req_ready     (req_ready),
      .line_x        (line_x),
      .line_y        (line_y),
      .ref_idx       (ref_idx),
      .blk_x         (blk_x),
      .blk_y         (blk_y),
      .blk_w         (blk_w),
      .blk_h         (blk_h),
      .res_ready     (res_ready),
      .res_valid     (res_valid),
      .res_dest_en   (res_dest_en),
      .res_hit       (res_hit),
      .res_way       (res_way),
      .res_set       (res_set),
      .res_miss_addr (res_miss_addr),
      .res_col_first (res_col_first),
      .res_col_last  (res_col_last),
      .res_row_first (res_row_first),
      .res_row_last  (res_row_last)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ------------------------------------------------
   // checks and reference model
   // ------------------------------------------------
   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
      assert (got == want) else begin
         val_errs++;
         $display("FAILED %s got %h expected %h at %0t", name, got, want, $time);
      end
   endtask

   task automatic model_accept();
      exp_t       e;
      line_id_t   id;
      int         s;
      int         used;
      int         a;
      int         lx0;
      int         ly0;
      int         bx0;
      int         by0;
      int         bx1;
      int         by1;
      e = '0;
      id = {ref_idx, line_y, line_x};
      s = (int'(line_y) % 4) * 8 + int'(line_x) % 8;
      lx0 = int'(line_x) * 8;
      ly0 = int'(line_y) * 4;
      bx0 = int'(blk_x);
      by0 = int'(blk_y);
      bx1 = bx0 + int'(blk_w) - 1;   // inclusive block edges
      by1 = by0 + int'(blk_h) - 1;
      e.set = set_addr_t'(s);
      e.dest_en = (bx1 >= bx0) && (by1 >= by0) && (bx0 <= lx0 + 7) && (bx1 >= lx0) &&
                  (by0 <= ly0 + 3) && (by1 >= ly0);
      if (e.dest_en) begin
         e.col_first = col_t'(((bx0 > lx0) ? bx0 : lx0) - lx0);
         e.col_last  = col_t'(((bx1 < lx0 + 7) ? bx1 : lx0 + 7) - lx0);
         e.row_first = row_t'(((by0 > ly0) ? by0 : ly0) - ly0);
         e.row_last  = row_t'(((by1 < ly0 + 3) ? by1 : ly0 + 3) - ly0);
         used = -1;
         for (int w = 0; w < `CB_WAYS; w++) begin
            if (m_valid[s][w] && m_line[s][w] == id)
               used = w;
         end
         e.hit = (used >= 0);
         if (!e.hit) begin
            for (int w = `CB_WAYS - 1; w >= 0; w--) begin
               if (!m_valid[s][w])
                  used = w;   // lowest invalid way
            end
            if (used < 0) begin
               for (int w = 0; w < `CB_WAYS; w++) begin
                  if (m_age[s][w] == 3)
                     used = w;
               end
            end
            m_valid[s][used] = 1'b1;
            m_line[s][used] = id;
            // 512 rows, 256 columns, 32 bytes per line
            e.addr = mem_addr_t'(((int'(ref_idx) * 512 + int'(line_y)) * 256 +
                                  int'(line_x)) * 32);
         end
         a = m_age[s][used];
         for (int w = 0; w < `CB_WAYS; w++) begin
            if (w == used)
               m_age[s][w] = 0;
            else if (m_age[s][w] < a)
               m_age[s][w]++;
         end
         e.way = way_t'(used);
      end
      e.timed = (ready_mode == 0);
      e.acc_cycle = cycle;
      exp_q.push_back(e);
   endtask

   always @(posedge clk) begin
      exp_t e;
      cycle++;
      if (!reset) begin
         if (stalled) begin
            assert (res_valid) else begin
               other_errs++;
               $display("res_valid dropped while the result was stalled at %0t", $time);
            end
            assert (res_bits == held_bits) else begin
               val_errs++;
               $display("FAILED res_bits got %h expected %h at %0t", res_bits, held_bits, $time);
            end
         end
         stalled = res_valid && !res_ready;
         held_bits = res_bits;
         if (res_valid && res_ready) begin
            assert (exp_q.size() != 0) else begin
               other_errs++;
               $display("result at %0t has no outstanding request", $time);
            end
            if (exp_q.size() != 0) begin
               e = exp_q.pop_front();
               n_checked++;
               check_val("res_dest_en", res_dest_en, e.dest_en);
               check_val("res_hit", res_hit, e.hit);
               check_val("res_way", res_way, e.way);
               check_val("res_set", res_set, e.set);
               check_val("res_miss_addr", res_miss_addr, e.addr);
               check_val("res_col_first", res_col_first, e.col_first);
               check_val("res_col_last", res_col_last, e.col_last);
               check_val("res_row_first", res_row_first, e.row_first);
               check_val("res_row_last", res_row_last, e.row_last);
               if (e.timed)
                  check_val("latency", cycle - e.acc_cycle, 3);   // rises on 2nd edge
            end
         end
         if (req_valid && req_ready)
            model_accept();
      end
   end

   // ------------------------------------------------
   // stimulus
   // ------------------------------------------------
   always @(posedge clk) begin
      #1;
      case (ready_mode)
         1: res_ready = ($urandom % 2) == 0;
         2: res_ready = ($urandom % 4) != 0;
         default: res_ready = 1'b1;
      endcase
   end

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic drain();
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic send_req(input int r, input int lx, input int ly, input int bx,
                           input int by, input int bw, input int bh);
      logic taken;
      req_valid = 1'b1;
      ref_idx = ref_idx_t'(r);
      line_x = line_x_t'(lx);
      line_y = line_y_t'(ly);
      blk_x = pix_x_t'(bx);
      blk_y = pix_y_t'(by);
      blk_w = dim_t'(bw);
      blk_h = dim_t'(bh);
      taken = 1'b0;
      while (!taken) begin
         @(negedge clk);
         taken = req_ready;   // stable until the next rising edge
         @(posedge clk);
         #1;
      end
      req_valid = 1'b0;
   endtask

   // block covers exactly the line
   task automatic send_full(input int r, input int lx, input int ly);
      send_req(r, lx, ly, lx * 8, ly * 4, 8, 4);
   endtask

   // few sets, many tags, blocks near the line
   task automatic send_random();
      int r;
      int lx;
      int ly;
      int bx;
      int by;
      int bw;
      int bh;
      r = int'($urandom % 2);
      lx = int'($urandom % 4) * 8 + int'($urandom % 2);
      ly = int'($urandom % 3) * 4;
      bx = lx * 8 + int'($urandom % 24) - 12;
      by = ly * 4 + int'($urandom % 12) - 6;
      bw = int'($urandom % 24);
      bh = int'($urandom % 12);
      if (bx < 0)
         bx = 0;
      if (by < 0)
         by = 0;
      send_req(r, lx, ly, bx, by, bw, bh);
   endtask

   initial begin
      void'($urandom(32'hbb144282));
      for (int s = 0; s < `CB_SETS; s++) begin
         for (int w = 0; w < `CB_WAYS; w++) begin
            m_line[s][w] = '0;
            m_valid[s][w] = 1'b0;
            m_age[s][w] = w;
         end
      end
      reset = 1'b1;
      req_valid = 1'b1;   // ignored while in reset
      line_x = '0;
      line_y = '0;
      ref_idx = '0;
      blk_x = '0;
      blk_y = '0;
      blk_w = '0;
      blk_h = '0;
      res_ready = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      req_valid = 1'b0;
      idle(2);
      check_val("res_valid", res_valid, 0);

      send_full(3, 10, 20);   // miss then hit
      idle(4);
      send_full(3, 10, 20);
      send_full(2, 33, 41);
      send_full(2, 33, 41);   // back to back, same set
      for (int r = 0; r < 5; r++)
         send_full(r, 12, 6);
      send_full(0, 12, 6);    // evicted earlier

      send_req(5, 20, 10, 100, 40, 16, 16);   // left of the line
      send_req(5, 20, 10, 160, 44, 8, 4);     // below
      send_req(5, 20, 10, 163, 38, 20, 4);
      send_req(5, 20, 10, 150, 42, 13, 64);
      send_req(5, 20, 10, 162, 41, 3, 2);
      send_req(5, 20, 10, 160, 40, 0, 4);     // empty block
      send_req(7, 50, 50, 0, 0, 8, 4);        // disabled, no fill
      send_full(7, 50, 50);
      send_req(1, 255, 511, 2040, 2044, 127, 127);
      drain();

      ready_mode = 1;
      repeat (300) begin
         send_random();
         if ($urandom % 4 == 0)
            idle(1);
      end
      drain();

      ready_mode = 2;
      repeat (2000) begin
         send_random();
         idle(int'($urandom % 2));
      end
      drain();

      // nothing may follow the last result
      idle(4);
      check_val("res_valid", res_valid, 0);
      $display("errors: %0d value, %0d other, %0d results checked",
               val_errs, other_errs, n_checked);
      if (val_errs + other_errs == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (n_req * 20) @(posedge clk);
      $display("timeout after %0d cycles with %0d results pending", n_req * 20, exp_q.size());
      $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire
